/* Bender.yml */
package:
  name: ecc_store

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ecc_pkg.sv
      - hdl/hamming_encoder.sv
      - hdl/ecc_array.sv
      - hdl/hamming_syndrome.sv
      - hdl/hamming_extract.sv
      - hdl/hamming_correct.sv
      - hdl/ecc_store.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_ecc_store.sv

/* hdl/ecc_array.sv */
// Codeword register array
// Overall parity and flip mask on write, registered read with valid pulse
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module ecc_array
  import ecc_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        wr_en,
  input  wire ecc_wr_req_t                 wr_req,
  input  wire logic [`ECC_BLOCK_WIDTH-1:0] block,
  input  wire logic                        rd_en,
  input  wire logic [`ECC_ADDR_WIDTH-1:0]  rd_addr,
  output ecc_word_t                        rd_word,
  output logic                             word_valid
);

  ecc_word_t mem [`ECC_DEPTH];
  ecc_word_t wr_word;

  // Overall parity makes the whole 16-bit word even
  assign wr_word = {^block, block};

  // Storage, cleared to the all-zero codeword
  // Mask bits flip the stored copy to model faults
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ECC_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_req.addr] <= wr_word ^ wr_req.flip;
    end
  end

  // Read data register
  // Same-cycle write to the same address is not visible yet
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

  // One valid per read, one cycle behind rd_en
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= rd_en;
    end
  end

endmodule

`default_nettype wire

/* hdl/ecc_pkg.sv */
// Types for the SECDED word store
// Stored codeword, write request, read response and decode status
`default_nettype none

package ecc_pkg;

  `include "hamming_params.svh"

  // Stored codeword
  // Overall parity on top, Hamming block below with position 1 at bit 0
  typedef struct packed {
    logic                        overall;
    logic [`ECC_BLOCK_WIDTH-1:0] block;
  } ecc_word_t;

  // Write request
  // Flip mask is XORed into the stored word, bit 15 hits the overall parity
  typedef struct packed {
    logic [`ECC_ADDR_WIDTH-1:0] addr;
    logic [`ECC_DATA_WIDTH-1:0] data;
    logic [`ECC_WORD_WIDTH-1:0] flip;
  } ecc_wr_req_t;

  // Decode outcome
  typedef enum logic [1:0] {
    ECC_OK        = 2'd0,
    ECC_CORRECTED = 2'd1,
    ECC_DOUBLE    = 2'd2
  } ecc_status_t;

  // Read response
  // err_pos is the 1-based block position, 16 for the overall bit, 0 otherwise
  typedef struct packed {
    logic [`ECC_DATA_WIDTH-1:0] data;
    logic [`ECC_POS_WIDTH-1:0]  err_pos;
    ecc_status_t                status;
  } ecc_rd_rsp_t;

endpackage

`default_nettype wire

/* hdl/ecc_store.sv */
// SECDED word store top level
// Encoder, codeword array and the three-part decoder
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module ecc_store
  import ecc_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       wr_en,
  input  wire ecc_wr_req_t                wr_req,
  input  wire logic                       rd_en,
  input  wire logic [`ECC_ADDR_WIDTH-1:0] rd_addr,
  output logic                            rd_valid,
  output ecc_rd_rsp_t                     rd_rsp
);

  logic [`ECC_BLOCK_WIDTH-1:0]  enc_block;
  ecc_word_t                    rd_word;
  logic                         word_valid;
  logic [`ECC_PARITY_WIDTH-1:0] syndrome;
  logic [`ECC_DATA_WIDTH-1:0]   raw_data;
  logic                         parity_err;

  // Write side encode, parity bits already sit inside the block
  hamming_encoder #(
    .DATA_WIDTH (`ECC_DATA_WIDTH)
  ) u_encoder (
    .data  (wr_req.data),
    .code  (),
    .block (enc_block)
  );

  ecc_array u_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_req     (wr_req),
    .block      (enc_block),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_word    (rd_word),
    .word_valid (word_valid)
  );

  // Syndrome and extraction both look at the read register
  hamming_syndrome u_syndrome (
    .rd_word  (rd_word),
    .syndrome (syndrome)
  );

  hamming_extract u_extract (
    .rd_word    (rd_word),
    .raw_data   (raw_data),
    .parity_err (parity_err)
  );

  hamming_correct u_correct (
    .word_valid (word_valid),
    .syndrome   (syndrome),
    .raw_data   (raw_data),
    .parity_err (parity_err),
    .rd_valid   (rd_valid),
    .rd_rsp     (rd_rsp)
  );

endmodule

`default_nettype wire

/* hdl/hamming_correct.sv */
// SECDED correction and classification
// Fixes single errors, flags double errors, forms the read response
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module hamming_correct
  import ecc_pkg::*;
(
  input  wire logic                         word_valid,
  input  wire logic [`ECC_PARITY_WIDTH-1:0] syndrome,
  input  wire logic [`ECC_DATA_WIDTH-1:0]   raw_data,
  input  wire logic                         parity_err,
  output logic                              rd_valid,
  output ecc_rd_rsp_t                       rd_rsp
);

  logic [`ECC_DATA_WIDTH-1:0] flip_mask;
  logic                       syn_hit;

  assign syn_hit = (syndrome != '0);

  // One-hot data flip for the position the syndrome names
  // Parity positions have no data bit, so they select nothing
  for (genvar pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin : gen_flip
    if ((pos & (pos - 1)) != 0) begin : gen_data_pos
      assign flip_mask[pos-1-$clog2(pos+1)] = (syndrome == pos);
    end
  end

  // Odd parity means one flip, even parity with a syndrome means two
  always_comb begin
    rd_rsp.data    = raw_data;
    rd_rsp.err_pos = '0;
    rd_rsp.status  = ECC_OK;
    if (parity_err) begin
      rd_rsp.status = ECC_CORRECTED;
      if (syn_hit) begin
        rd_rsp.data    = raw_data ^ flip_mask;
        rd_rsp.err_pos = {1'b0, syndrome};
      end else begin
        // Only the overall bit flipped
        rd_rsp.err_pos = `ECC_POS_WIDTH'(`ECC_WORD_WIDTH);
      end
    end else if (syn_hit) begin
      rd_rsp.status = ECC_DOUBLE;
    end
  end

  // Decode is combinational, valid tracks the read register
  assign rd_valid = word_valid;

endmodule

`default_nettype wire

/* hdl/hamming_encoder.sv */
// Combinational Hamming encoder
// Parity bits sit at power-of-two positions, data bits fill the gaps
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module hamming_encoder #(
  parameter  int DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  wire logic [DATA_WIDTH-1:0]   data,
  output logic      [PARITY_WIDTH-1:0] code,
  output logic      [BLOCK_WIDTH-1:0]  block
);

  // Full Hamming length for this parity count
  localparam int PAD_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam int PAD_BLOCK_WIDTH = PAD_DATA_WIDTH + PARITY_WIDTH;

  logic [PAD_DATA_WIDTH-1:0]  data_padded;
  logic [PAD_BLOCK_WIDTH-1:0] data_block;
  logic [PAD_BLOCK_WIDTH-1:0] block_padded;
  logic [PARITY_WIDTH-1:0]    parity;

  // Unused upper data bits are zero so they fall out of the parity
  assign data_padded = {{(PAD_DATA_WIDTH - DATA_WIDTH){1'b0}}, data};

  // Parity slots are left empty in the data-only block
  for (genvar i = 0; i < PARITY_WIDTH; i++) begin : gen_parity_slot
    assign data_block[2**i-1] = 1'b0;
  end

  // Data runs between parity slot 2**(k-1) and the next one at 2**k
  for (genvar k = 2; k <= PARITY_WIDTH; k++) begin : gen_data_run
    localparam int BLK_LO = 2**(k-1);
    localparam int BLK_HI = 2**k - 2;
    localparam int DAT_LO = 2**(k-1) - k;
    localparam int DAT_HI = 2**k - k - 2;
    assign data_block[BLK_HI:BLK_LO] = data_padded[DAT_HI:DAT_LO];
  end

  // Parity i covers every 1-based position with bit i set
  always_comb begin
    parity = '0;
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      for (int pos = 1; pos <= PAD_BLOCK_WIDTH; pos++) begin
        if (((pos >> i) & 1) == 1) begin
          parity[i] = parity[i] ^ data_block[pos-1];
        end
      end
    end
  end

  // Drop the parity bits into their slots
  always_comb begin
    block_padded = data_block;
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      block_padded[2**i-1] = parity[i];
    end
  end

  assign code  = parity;
  // Top positions only hold padding when DATA_WIDTH is short
  assign block = block_padded[BLOCK_WIDTH-1:0];

endmodule

`default_nettype wire

/* hdl/hamming_extract.sv */
// Data extraction and overall parity check
// Pulls data from non-power-of-two positions, reduces all 16 bits
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module hamming_extract
  import ecc_pkg::*;
(
  input  wire ecc_word_t                  rd_word,
  output logic      [`ECC_DATA_WIDTH-1:0] raw_data,
  output logic                            parity_err
);

  // Data index of position pos skips the $clog2(pos+1) parity slots below it
  for (genvar pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin : gen_pick
    if ((pos & (pos - 1)) != 0) begin : gen_data_pos
      assign raw_data[pos-1-$clog2(pos+1)] = rd_word.block[pos-1];
    end
  end

  // Even over the whole word when intact
  // Any odd number of flips shows up here, the overall bit included
  assign parity_err = ^rd_word;

endmodule

`default_nettype wire

/* hdl/hamming_syndrome.sv */
// Syndrome generator for the stored Hamming block
// Recomputes each parity bit and folds in the stored one
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module hamming_syndrome
  import ecc_pkg::*;
(
  input  wire ecc_word_t                    rd_word,
  output logic      [`ECC_PARITY_WIDTH-1:0] syndrome
);

  logic [`ECC_BLOCK_WIDTH-1:0] blk;

  // Overall parity bit plays no part here
  assign blk = rd_word.block;

  // Same position rule as the encoder
  // Stored parity at 2**i is covered too, so a clean block gives zero
  always_comb begin
    syndrome = '0;
    for (int i = 0; i < `ECC_PARITY_WIDTH; i++) begin
      for (int pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin
        if (((pos >> i) & 1) == 1) begin
          syndrome[i] = syndrome[i] ^ blk[pos-1];
        end
      end
    end
  end

  // A single flip at position p sets exactly the bits of p
  // so the syndrome reads back as that position

endmodule

`default_nettype wire

/* include/hamming_params.svh */
// Width macros for the SECDED word store
// Hamming parity-width and data-width helper macros
`ifndef HAMMING_PARAMS_SVH
`define HAMMING_PARAMS_SVH

// Smallest parity count p that covers dw data bits, i.e. 2**p >= dw + p + 1
`define GET_HAMMING_PARITY_WIDTH(dw) ($clog2((dw) + $clog2((dw) + 1) + 1))

// Largest data width that p parity bits can protect
`define GET_HAMMING_DATA_WIDTH(pw) ((2 ** (pw)) - (pw) - 1)

// Data bits per stored word
`define ECC_DATA_WIDTH 11

// Hamming parity bits for the data width above
`define ECC_PARITY_WIDTH `GET_HAMMING_PARITY_WIDTH(`ECC_DATA_WIDTH)

// Hamming block, data plus parity, 15 bits
`define ECC_BLOCK_WIDTH (`ECC_DATA_WIDTH + `ECC_PARITY_WIDTH)

// Stored word, block plus the overall parity bit
`define ECC_WORD_WIDTH (`ECC_BLOCK_WIDTH + 1)

// Error position field, 0 to 16
`define ECC_POS_WIDTH 5

// Array geometry
`define ECC_DEPTH 8
`define ECC_ADDR_WIDTH 3

`endif

/* tb.f */
+incdir+include
hdl/ecc_pkg.sv
hdl/hamming_encoder.sv
hdl/ecc_array.sv
hdl/hamming_syndrome.sv
hdl/hamming_extract.sv
hdl/hamming_correct.sv
hdl/ecc_store.sv
tb/tb_ecc_store.sv

/* tb/tb_ecc_store.sv */
// Directed testbench for the SECDED word store
// Reference encoder, Galois LFSR, compare tasks and five directed tests
`timescale 1ns/1ns
`default_nettype none

`include "hamming_params.svh"

module tb_ecc_store
  import ecc_pkg::*;
();

  logic                       clk;
  logic                       rst_n;
  logic                       wr_en;
  ecc_wr_req_t                wr_req;
  logic                       rd_en;
  logic [`ECC_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_valid;
  ecc_rd_rsp_t                rd_rsp;

  // Bookkeeping
  int          pass_count;
  int          fail_count;
  int          test_errors;
  logic [15:0] lfsr_state;
  logic [`ECC_DATA_WIDTH-1:0] ref_data [`ECC_DEPTH];

  ecc_store dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_req   (wr_req),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_rsp   (rd_rsp)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic out_bit;
    out_bit = s[0];
    s = s >> 1;
    if (out_bit) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  // Fills LSB first with one LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Reference codeword
  // Data fills non-power-of-two positions in order
  // Parity i covers positions with bit i set
  function automatic logic [`ECC_WORD_WIDTH-1:0] ref_encode(
    input logic [`ECC_DATA_WIDTH-1:0] d
  );
    logic [`ECC_BLOCK_WIDTH-1:0] blk;
    int                          idx;
    blk = '0;
    idx = 0;
    for (int pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        blk[pos-1] = d[idx];
        idx++;
      end
    end
    for (int i = 0; i < `ECC_PARITY_WIDTH; i++) begin
      for (int pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin
        if (((pos >> i) & 1) == 1) begin
          blk[(1 << i) - 1] = blk[(1 << i) - 1] ^ blk[pos-1];
        end
      end
    end
    return {^blk, blk};
  endfunction

  // Data bits as seen in a stored word without correction
  function automatic logic [`ECC_DATA_WIDTH-1:0] ref_extract(
    input logic [`ECC_WORD_WIDTH-1:0] w
  );
    logic [`ECC_DATA_WIDTH-1:0] d;
    int                         idx;
    d = '0;
    idx = 0;
    for (int pos = 1; pos <= `ECC_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        d[idx] = w[pos-1];
        idx++;
      end
    end
    return d;
  endfunction

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    fail_count++;
    test_errors++;
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_data(input string name, input logic [`ECC_DATA_WIDTH-1:0] got,
                            input logic [`ECC_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_status(input string name, input ecc_status_t got,
                              input ecc_status_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_pos(input string name, input logic [`ECC_POS_WIDTH-1:0] got,
                           input logic [`ECC_POS_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Single write cycle with inputs changing 2 ns after the edge
  task automatic write_word(input logic [`ECC_ADDR_WIDTH-1:0] addr,
                            input logic [`ECC_DATA_WIDTH-1:0] data,
                            input logic [`ECC_WORD_WIDTH-1:0] flip);
    @(posedge clk);
    #2;
    wr_en       = 1'b1;
    wr_req.addr = addr;
    wr_req.data = data;
    wr_req.flip = flip;
    @(posedge clk);
    #2;
    wr_en = 1'b0;
    wr_req = '0;
  endtask

  // Pulse rd_en, wait for rd_valid, expect it one cycle later and one cycle wide
  task automatic read_word(input logic [`ECC_ADDR_WIDTH-1:0] addr, output ecc_rd_rsp_t rsp);
    int cycles;
    rsp = '0;
    @(posedge clk);
    #2;
    rd_en   = 1'b1;
    rd_addr = addr;
    @(posedge clk);
    #2;
    rd_en  = 1'b0;
    cycles = 0;
    while (rd_valid !== 1'b1 && cycles < 10) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (rd_valid !== 1'b1) begin
      report_failure($sformatf("no rd_valid within 10 cycles of a read of address %0d", addr));
    end else begin
      if (cycles != 0) begin
        report_failure($sformatf("rd_valid came %0d cycles late", cycles));
      end
      rsp = rd_rsp;
      @(posedge clk);
      #2;
      // Valid is a single-cycle pulse
      check_valid("rd_valid", rd_valid, 1'b0);
    end
  endtask

  task automatic test_reset_state();
    ecc_rd_rsp_t rsp;
    check_valid("rd_valid", rd_valid, 1'b0);
    read_word(3'd5, rsp);
    check_data("rd_rsp.data", rsp.data, '0);
    check_status("rd_rsp.status", rsp.status, ECC_OK);
    check_pos("rd_rsp.err_pos", rsp.err_pos, '0);
    finish_test("reset_state");
  endtask

  task automatic test_clean_round_trip();
    ecc_rd_rsp_t rsp;
    for (int a = 0; a < `ECC_DEPTH; a++) begin
      ref_data[a] = rand_bits(`ECC_DATA_WIDTH);
      write_word(a, ref_data[a], '0);
    end
    for (int a = 0; a < `ECC_DEPTH; a++) begin
      read_word(a, rsp);
      check_data("rd_rsp.data", rsp.data, ref_data[a]);
      check_status("rd_rsp.status", rsp.status, ECC_OK);
      check_pos("rd_rsp.err_pos", rsp.err_pos, '0);
    end
    finish_test("clean_round_trip");
  endtask

  // Mask bit p is block position p+1
  // Bit 15 is the overall bit at 16
  task automatic test_single_correct();
    ecc_rd_rsp_t                rsp;
    logic [`ECC_DATA_WIDTH-1:0] data;
    for (int p = 0; p < `ECC_WORD_WIDTH; p++) begin
      data = rand_bits(`ECC_DATA_WIDTH);
      write_word(p % `ECC_DEPTH, data, 16'h1 << p);
      read_word(p % `ECC_DEPTH, rsp);
      check_data("rd_rsp.data", rsp.data, data);
      check_status("rd_rsp.status", rsp.status, ECC_CORRECTED);
      check_pos("rd_rsp.err_pos", rsp.err_pos, p + 1);
    end
    finish_test("single_correct");
  endtask

  // Raw data passes through uncorrected on a double flip
  task automatic test_double_detect();
    ecc_rd_rsp_t                rsp;
    logic [`ECC_DATA_WIDTH-1:0] data;
    logic [`ECC_WORD_WIDTH-1:0] mask;
    logic [3:0]                 b1;
    logic [3:0]                 b2;
    for (int i = 0; i < 12; i++) begin
      b1 = rand_bits(4);
      b2 = rand_bits(4);
      if (b2 == b1) begin
        b2 = b1 ^ 4'h1;
      end
      mask = (16'h1 << b1) | (16'h1 << b2);
      data = rand_bits(`ECC_DATA_WIDTH);
      write_word(i % `ECC_DEPTH, data, mask);
      read_word(i % `ECC_DEPTH, rsp);
      check_data("rd_rsp.data", rsp.data, ref_extract(ref_encode(data) ^ mask));
      check_status("rd_rsp.status", rsp.status, ECC_DOUBLE);
      check_pos("rd_rsp.err_pos", rsp.err_pos, '0);
    end
    finish_test("double_detect");
  endtask

  // Two reads in flight with responses in issue order
  task automatic test_back_to_back();
    logic [`ECC_DATA_WIDTH-1:0] d_a;
    logic [`ECC_DATA_WIDTH-1:0] d_b;
    d_a = rand_bits(`ECC_DATA_WIDTH);
    d_b = rand_bits(`ECC_DATA_WIDTH);
    write_word(3'd2, d_a, '0);
    write_word(3'd6, d_b, '0);
    @(posedge clk);
    #2;
    rd_en   = 1'b1;
    rd_addr = 3'd2;
    @(posedge clk);
    #2;
    rd_addr = 3'd6;
    // First response
    check_valid("rd_valid", rd_valid, 1'b1);
    check_data("rd_rsp.data", rd_rsp.data, d_a);
    check_status("rd_rsp.status", rd_rsp.status, ECC_OK);
    @(posedge clk);
    #2;
    rd_en = 1'b0;
    // Second response right behind it
    check_valid("rd_valid", rd_valid, 1'b1);
    check_data("rd_rsp.data", rd_rsp.data, d_b);
    check_status("rd_rsp.status", rd_rsp.status, ECC_OK);
    @(posedge clk);
    #2;
    check_valid("rd_valid", rd_valid, 1'b0);
    finish_test("back_to_back");
  endtask

  initial begin
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    lfsr_state  = 16'd67;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_req      = '0;
    rd_en       = 1'b0;
    rd_addr     = '0;
    // Two cycles of reset with release off the edge
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_state();
    test_clean_round_trip();
    test_single_correct();
    test_double_detect();
    test_back_to_back();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
